// File: hw/rtfb_pkg.sv
/*
 * Shared definitions for the real-time feedback sampling subsystem.
 * Holds the channel count, the snapshot layout constants, the field and
 * state enums and the index types used by every block and the testbench.
 */

package rtfb_pkg;

   // ------------------------------------------------------------------------
   // Sizes and snapshot layout
   // ------------------------------------------------------------------------

   localparam int NUM_CHAN    = 4;   // Axis channels on the board
   localparam int NUM_FIELDS  = 7;   // Feedback words per channel
   localparam int SNAP_DEPTH  = 64;  // Full 6-bit snapshot address space
   localparam int GLOBAL_BASE = 4;   // Quadlets 0..3 are timestamp + globals

   // Timestamp, three globals, then the channel words
   localparam int BLK_QUADS = GLOBAL_BASE + NUM_FIELDS * NUM_CHAN;

   // Word of field f and channel c sits at GLOBAL_BASE + f * NUM_CHAN + c
   // so all channels of one field sit next to each other

   // ------------------------------------------------------------------------
   // Index and data types
   // ------------------------------------------------------------------------

   typedef logic [1:0]  chan_idx_t;   // Channel 0..NUM_CHAN-1
   typedef logic [5:0]  snap_addr_t;  // Snapshot quadlet address
   typedef logic [31:0] quad_t;       // One quadlet

   // Feedback word within a channel and its field number in the layout
   typedef enum logic [2:0] {
      FB_ADC          = 3'd0,  // Motor current and pot reading
      FB_ENC_POS      = 3'd1,  // Quadrature position
      FB_ENC_PERIOD   = 3'd2,  // Velocity as a period count
      FB_ENC_QTR1     = 3'd3,  // Last quarter period
      FB_ENC_QTR5     = 3'd4,  // Quarter period five edges back
      FB_ENC_RUN      = 3'd5,  // Running counter since last edge
      FB_MOTOR_STATUS = 3'd6
   } fb_field_e;

   // Sampler FSM
   typedef enum logic {
      SD_IDLE     = 1'b0,
      SD_SAMPLING = 1'b1
   } sd_state_e;

   // Block reader FSM
   typedef enum logic {
      BR_IDLE   = 1'b0,
      BR_STREAM = 1'b1
   } br_state_e;

endpackage

// File: hw/chan_fb_if.sv
/*
 * Feedback path between the sampler and the channel register file.
 * The sampler selects a channel, the register file answers with the
 * seven feedback words of that channel in the same cycle.
 */

`timescale 1ns/1ps

interface chan_fb_if;
   import rtfb_pkg::*;

   chan_idx_t chan;          // Selected channel driven by the sampler
   quad_t     adc;           // Words below come from the register file
   quad_t     enc_pos;
   quad_t     enc_period;
   quad_t     enc_qtr1;
   quad_t     enc_qtr5;
   quad_t     enc_run;
   quad_t     motor_status;

   // Sampler side picks the channel and reads the words
   modport sampler (
      output chan,
      input  adc, enc_pos, enc_period, enc_qtr1, enc_qtr5, enc_run, motor_status
   );

   // Register file side decodes chan and drives the words
   modport regs (
      input  chan,
      output adc, enc_pos, enc_period, enc_qtr1, enc_qtr5, enc_run, motor_status
   );

endinterface

// File: hw/chan_regs.sv
/*
 * Feedback register file, seven quadlets per axis channel.
 * Encoder and ADC logic write single words through a strobe that is always
 * accepted; the sampler reads all words of one channel combinationally.
 */

`timescale 1ns/1ps

module chan_regs (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 wr_valid,   // Write strobe without ready
   input  rtfb_pkg::chan_idx_t  wr_chan,
   input  rtfb_pkg::fb_field_e  wr_field,
   input  rtfb_pkg::quad_t      wr_data,
   chan_fb_if.regs              fb
);
   import rtfb_pkg::*;

   // ------------------------------------------------------------------------
   // Storage
   // ------------------------------------------------------------------------

   quad_t regs_q [NUM_CHAN][NUM_FIELDS];   // [channel][field]

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int c = 0; c < NUM_CHAN; c++) begin
            for (int f = 0; f < NUM_FIELDS; f++) begin
               regs_q[c][f] <= '0;
            end
         end
      end else if (wr_valid) begin
         regs_q[wr_chan][wr_field] <= wr_data;   // Seen by the sampler next cycle
      end
   end

   // ------------------------------------------------------------------------
   // Read side
   // ------------------------------------------------------------------------

   // Pure mux on the stored words, so a write landing in the same
   // cycle as a sample of that channel is captured with its old value
   assign fb.adc          = regs_q[fb.chan][FB_ADC];
   assign fb.enc_pos      = regs_q[fb.chan][FB_ENC_POS];
   assign fb.enc_period   = regs_q[fb.chan][FB_ENC_PERIOD];
   assign fb.enc_qtr1     = regs_q[fb.chan][FB_ENC_QTR1];
   assign fb.enc_qtr5     = regs_q[fb.chan][FB_ENC_QTR5];
   assign fb.enc_run      = regs_q[fb.chan][FB_ENC_RUN];
   assign fb.motor_status = regs_q[fb.chan][FB_MOTOR_STATUS];

   // ------------------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------------------

   // Field code 7 has no storage behind it; the front end logic must not
   // produce it on a live write
   a_wr_field_legal : assert property (
      @(posedge clk) disable iff (reset)
      wr_valid |-> (int'(wr_field) < NUM_FIELDS)
   ) else $error("chan_regs: write with illegal field code %0d", wr_field);

endmodule

// File: hw/sample_data.sv
/*
 * Snapshot sampler for the real-time block read.
 * On start it walks all channels, one per cycle, and copies the timestamp,
 * the global status words and each channel's feedback into a 64-quadlet
 * memory. The block reader reads that memory through a combinational port.
 */

`timescale 1ns/1ps

module sample_data (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  start,       // Accepted sample request
   input  rtfb_pkg::quad_t       reg_status,  // Board status
   input  rtfb_pkg::quad_t       reg_digio,   // Digital I/O
   input  rtfb_pkg::quad_t       reg_temp,    // Temperature
   input  rtfb_pkg::snap_addr_t  rd_addr,     // From the block reader
   chan_fb_if.sampler            fb,
   output logic                  busy,
   output rtfb_pkg::quad_t       rd_data,
   output rtfb_pkg::quad_t       timestamp    // Cycles since last sample
);
   import rtfb_pkg::*;

   // Quadlet address of one channel word in the snapshot
   function automatic snap_addr_t fb_addr(input int field, input chan_idx_t ch);
      return snap_addr_t'(GLOBAL_BASE + field * NUM_CHAN + int'(ch));
   endfunction

   sd_state_e state;
   chan_idx_t chan_q;
   quad_t     ts_q;
   quad_t     snap_mem [SNAP_DEPTH];
   quad_t     fb_words [NUM_FIELDS];   // Interface words indexed by field
   logic      first_cycle;             // Sampling chan 0 when the globals go in too

   assign busy        = (state != SD_IDLE);
   assign first_cycle = (state == SD_SAMPLING) && (chan_q == '0);
   assign fb.chan     = chan_q;
   assign timestamp   = ts_q;
   assign rd_data     = snap_mem[rd_addr];   // Combinational read port

   assign fb_words[FB_ADC]          = fb.adc;
   assign fb_words[FB_ENC_POS]      = fb.enc_pos;
   assign fb_words[FB_ENC_PERIOD]   = fb.enc_period;
   assign fb_words[FB_ENC_QTR1]     = fb.enc_qtr1;
   assign fb_words[FB_ENC_QTR5]     = fb.enc_qtr5;
   assign fb_words[FB_ENC_RUN]      = fb.enc_run;
   assign fb_words[FB_MOTOR_STATUS] = fb.motor_status;

   // ------------------------------------------------------------------------
   // FSM, channel stepper and timestamp
   // ------------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= SD_IDLE;
         chan_q <= '0;
         ts_q   <= '0;
      end else begin
         // Free running count restarted from 0 as the old value is captured
         ts_q <= first_cycle ? '0 : ts_q + 32'd1;
         case (state)
            SD_IDLE: begin
               if (start) begin
                  chan_q <= '0;
                  state  <= SD_SAMPLING;
               end
            end
            SD_SAMPLING: begin
               if (chan_q == chan_idx_t'(NUM_CHAN - 1)) begin
                  chan_q <= '0;       // Last channel done
                  state  <= SD_IDLE;
               end else begin
                  chan_q <= chan_q + chan_idx_t'(1);
               end
            end
            default: state <= SD_IDLE;
         endcase
      end
   end

   // ------------------------------------------------------------------------
   // Snapshot memory
   // ------------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < SNAP_DEPTH; i++) begin
            snap_mem[i] <= '0;
         end
      end else if (state == SD_SAMPLING) begin
         if (first_cycle) begin
            snap_mem[0] <= ts_q;          // Value before the restart
            snap_mem[1] <= reg_status;
            snap_mem[2] <= reg_digio;
            snap_mem[3] <= reg_temp;
         end
         for (int f = 0; f < NUM_FIELDS; f++) begin
            snap_mem[fb_addr(f, chan_q)] <= fb_words[f];
         end
      end
   end

   // ------------------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------------------

   // The top level must hold requests off until the walk is over
   a_start_idle : assert property (
      @(posedge clk) disable iff (reset)
      start |-> (state == SD_IDLE)
   ) else $error("sample_data: start while sampling");

   // The walk stops on the last channel and never steps past it
   a_chan_walk : assert property (
      @(posedge clk) disable iff (reset)
      start |-> ##(NUM_CHAN) (busy && chan_q == chan_idx_t'(NUM_CHAN - 1)) ##1 !busy
   ) else $error("sample_data: channel walk did not end on the last channel");

endmodule

// File: hw/block_reader.sv
/*
 * Block reader for the real-time feedback snapshot.
 * After a start it streams quadlets 0..BLK_QUADS-1 out on a valid/ready
 * handshake, marking the final one with last. Data is held while stalled.
 */

`timescale 1ns/1ps

module block_reader (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  start,      // Accepted block read start
   input  rtfb_pkg::quad_t       rd_data,    // Snapshot word at rd_addr
   input  logic                  blk_ready,
   output logic                  busy,
   output rtfb_pkg::snap_addr_t  rd_addr,
   output logic                  blk_valid,
   output rtfb_pkg::quad_t       blk_data,
   output logic                  blk_last
);
   import rtfb_pkg::*;

   localparam snap_addr_t LAST_ADDR = snap_addr_t'(BLK_QUADS - 1);

   br_state_e  state;
   snap_addr_t addr_q;   // Next quadlet to load into the output register
   logic       xfer;     // Handshake on the stream

   assign busy    = (state != BR_IDLE);
   assign rd_addr = addr_q;              // Zero whenever idle
   assign xfer    = blk_valid && blk_ready;

   // ------------------------------------------------------------------------
   // FSM and output register
   // ------------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= BR_IDLE;
         addr_q    <= '0;
         blk_valid <= 1'b0;
         blk_data  <= '0;
         blk_last  <= 1'b0;
      end else begin
         case (state)
            BR_IDLE: begin
               if (start) begin
                  blk_data  <= rd_data;                // Quadlet 0
                  blk_last  <= (addr_q == LAST_ADDR);
                  blk_valid <= 1'b1;
                  addr_q    <= addr_q + snap_addr_t'(1);
                  state     <= BR_STREAM;
               end
            end
            BR_STREAM: begin
               if (xfer) begin
                  if (blk_last) begin
                     // Final quadlet taken so rewind for the next block
                     blk_valid <= 1'b0;
                     blk_last  <= 1'b0;
                     addr_q    <= '0;
                     state     <= BR_IDLE;
                  end else begin
                     blk_data <= rd_data;
                     blk_last <= (addr_q == LAST_ADDR);
                     addr_q   <= addr_q + snap_addr_t'(1);
                  end
               end
            end
            default: state <= BR_IDLE;
         endcase
      end
   end

   // ------------------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------------------

   // A stalled word toward the packet engine does not move
   a_hold_on_stall : assert property (
      @(posedge clk) disable iff (reset)
      (blk_valid && !blk_ready) |=> (blk_valid && $stable(blk_data) && $stable(blk_last))
   ) else $error("block_reader: stream changed while stalled");

endmodule

// File: hw/rt_feedback_top.sv
/*
 * Real-time feedback sampling subsystem, top level.
 * Connects the channel register file, the snapshot sampler and the block
 * reader, and keeps sampling and streaming from overlapping so every block
 * read out is one consistent snapshot.
 */

`timescale 1ns/1ps

module rt_feedback_top (
   input  logic                 clk,
   input  logic                 reset,
   // Sample request
   input  logic                 sample_valid,
   output logic                 sample_ready,
   input  rtfb_pkg::quad_t      reg_status,
   input  rtfb_pkg::quad_t      reg_digio,
   input  rtfb_pkg::quad_t      reg_temp,
   // Channel feedback writes
   input  logic                 fb_wr_valid,
   input  rtfb_pkg::chan_idx_t  fb_wr_chan,
   input  rtfb_pkg::fb_field_e  fb_wr_field,
   input  rtfb_pkg::quad_t      fb_wr_data,
   // Block read
   input  logic                 rd_start_valid,
   output logic                 rd_start_ready,
   output logic                 blk_valid,
   input  logic                 blk_ready,
   output rtfb_pkg::quad_t      blk_data,
   output logic                 blk_last,
   output rtfb_pkg::quad_t      timestamp
);
   import rtfb_pkg::*;

   logic       sd_busy;       // Sampler walking the channels
   logic       br_busy;       // Block stream in progress
   logic       sample_start;
   logic       rd_start;
   snap_addr_t rd_addr;
   quad_t      rd_data;

   chan_fb_if fb_if ();

   // ------------------------------------------------------------------------
   // Arbitration
   // ------------------------------------------------------------------------

   // Both sides need everything idle; on a tie the sample goes first so
   // the read that follows sees fresh data
   assign sample_ready   = !sd_busy && !br_busy;
   assign rd_start_ready = !sd_busy && !br_busy && !sample_valid;
   assign sample_start   = sample_valid && sample_ready;
   assign rd_start       = rd_start_valid && rd_start_ready;

   // ------------------------------------------------------------------------
   // Blocks
   // ------------------------------------------------------------------------

   chan_regs chan_regs_inst (
      .clk      (clk),
      .reset    (reset),
      .wr_valid (fb_wr_valid),
      .wr_chan  (fb_wr_chan),
      .wr_field (fb_wr_field),
      .wr_data  (fb_wr_data),
      .fb       (fb_if.regs)
   );

   sample_data sample_data_inst (
      .clk        (clk),
      .reset      (reset),
      .start      (sample_start),
      .reg_status (reg_status),
      .reg_digio  (reg_digio),
      .reg_temp   (reg_temp),
      .rd_addr    (rd_addr),
      .fb         (fb_if.sampler),
      .busy       (sd_busy),
      .rd_data    (rd_data),
      .timestamp  (timestamp)
   );

   block_reader block_reader_inst (
      .clk       (clk),
      .reset     (reset),
      .start     (rd_start),
      .rd_data   (rd_data),
      .blk_ready (blk_ready),
      .busy      (br_busy),
      .rd_addr   (rd_addr),
      .blk_valid (blk_valid),
      .blk_data  (blk_data),
      .blk_last  (blk_last)
   );

endmodule

// File: test/tb_rt_feedback.sv
/*
 * Directed testbench for the real-time feedback sampling subsystem.
 * Keeps its own copy of the channel words and of the expected snapshot,
 * requests samples, streams blocks out and compares every quadlet.
 */

`timescale 1ns/1ps

module tb_rt_feedback;
   import rtfb_pkg::*;

   logic      clk = 1'b0;
   logic      reset;
   logic      sample_valid, sample_ready;
   quad_t     reg_status, reg_digio, reg_temp;
   logic      fb_wr_valid;
   chan_idx_t fb_wr_chan;
   fb_field_e fb_wr_field;
   quad_t     fb_wr_data;
   logic      rd_start_valid, rd_start_ready;
   logic      blk_valid, blk_ready, blk_last;
   quad_t     blk_data, timestamp;

   integer seed = 32'ha25f;
   int     errors = 0;
   int     timeouts = 0;
   int     cycle_cnt = 0;                    // Rising edges seen so far
   int     zero_edge;                        // Edge where the timestamp last restarted
   quad_t  model_regs [NUM_CHAN][NUM_FIELDS];
   quad_t  snap_exp [BLK_QUADS];             // Block the next read must return

   always #5 clk = ~clk;
   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   rt_feedback_top rt_feedback_top_inst (
      .clk(clk), .reset(reset),
      .sample_valid(sample_valid), .sample_ready(sample_ready),
      .reg_status(reg_status), .reg_digio(reg_digio), .reg_temp(reg_temp),
      .fb_wr_valid(fb_wr_valid), .fb_wr_chan(fb_wr_chan),
      .fb_wr_field(fb_wr_field), .fb_wr_data(fb_wr_data),
      .rd_start_valid(rd_start_valid), .rd_start_ready(rd_start_ready),
      .blk_valid(blk_valid), .blk_ready(blk_ready), .blk_data(blk_data),
      .blk_last(blk_last), .timestamp(timestamp)
   );

   // ------------------------------------------------------------------------
   // Helpers and compares
   // ------------------------------------------------------------------------

   function automatic quad_t next_rand();
      return quad_t'($random(seed));
   endfunction

   function automatic logic pick_ready(input bit stall);
      quad_t r;
      r = next_rand();
      return stall ? r[0] : 1'b1;            // About half the cycles stalled
   endfunction

   task automatic check_quad(input string name, input quad_t exp, input quad_t act);
      if (act !== exp) begin
         errors++;
         $display("Fail %s: expected %08h, actual %08h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("Fail %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic write_chan(input chan_idx_t c, input fb_field_e f, input quad_t data);
      @(posedge clk);
      fb_wr_valid <= 1'b1;
      fb_wr_chan  <= c;
      fb_wr_field <= f;
      fb_wr_data  <= data;
      @(posedge clk);                        // Write lands on this edge
      fb_wr_valid <= 1'b0;
      model_regs[c][f] = data;
   endtask

   task automatic randomize_chan_words();
      for (int c = 0; c < NUM_CHAN; c++)
         for (int f = 0; f < NUM_FIELDS; f++)
            write_chan(chan_idx_t'(c), fb_field_e'(f), next_rand());
   endtask

   // Request a sample with random globals and update the expected block
   task automatic do_sample(input string name);
      int    n;
      int    accept;
      quad_t st;
      quad_t dio;
      quad_t tmp;
      st  = next_rand();
      dio = next_rand();
      tmp = next_rand();
      @(posedge clk);
      sample_valid <= 1'b1;
      reg_status   <= st;
      reg_digio    <= dio;
      reg_temp     <= tmp;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!sample_ready && n < 200);
      if (!sample_ready) begin
         $display("%s: sample request was never accepted", name);
         timeouts++;
      end
      @(posedge clk);                        // Accept edge
      sample_valid <= 1'b0;
      accept = cycle_cnt;
      snap_exp[0] = quad_t'(accept - zero_edge);   // Old count is taken one edge later
      snap_exp[1] = st;
      snap_exp[2] = dio;
      snap_exp[3] = tmp;
      for (int c = 0; c < NUM_CHAN; c++)
         for (int f = 0; f < NUM_FIELDS; f++)
            snap_exp[GLOBAL_BASE + f * NUM_CHAN + c] = model_regs[c][f];
      zero_edge = accept + 1;
      @(negedge clk);
      @(negedge clk);
      check_quad({name, " timestamp restart"}, '0, timestamp);
      check_bit({name, " sample_ready while sampling"}, 1'b0, sample_ready);
      check_bit({name, " rd_start_ready while sampling"}, 1'b0, rd_start_ready);
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!sample_ready && n < 20);
      if (!sample_ready) begin
         $display("%s: sampler stayed busy after the sample", name);
         timeouts++;
      end
   endtask

   // Start a block read and check every quadlet with optional back-pressure
   task automatic read_block(input string name, input bit stall);
      quad_t exp_blk [BLK_QUADS];
      quad_t held_data;
      logic  held_last;
      logic  stalled;
      int    idx;
      int    n;
      exp_blk = snap_exp;                    // Later samples must not leak in
      @(posedge clk);
      rd_start_valid <= 1'b1;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!rd_start_ready && n < 200);
      if (!rd_start_ready) begin
         $display("%s: block read start was never accepted", name);
         timeouts++;
      end
      @(posedge clk);                        // Start accepted
      rd_start_valid <= 1'b0;
      blk_ready      <= pick_ready(stall);
      idx     = 0;
      n       = 0;
      stalled = 1'b0;
      while (idx < BLK_QUADS && n < 1000) begin
         @(negedge clk);
         n++;
         check_bit({name, " blk_valid"}, 1'b1, blk_valid);
         check_bit({name, " sample_ready while streaming"}, 1'b0, sample_ready);
         check_bit({name, " rd_start_ready while streaming"}, 1'b0, rd_start_ready);
         if (stalled) begin
            check_quad({name, " data held"}, held_data, blk_data);
            check_bit({name, " last held"}, held_last, blk_last);
         end
         stalled = !blk_ready;
         if (blk_ready) begin                // Handshake on the next edge
            check_quad($sformatf("%s q%0d", name, idx), exp_blk[idx], blk_data);
            check_bit($sformatf("%s last q%0d", name, idx), idx == BLK_QUADS - 1, blk_last);
            idx++;
         end else begin
            held_data = blk_data;
            held_last = blk_last;
         end
         @(posedge clk);
         blk_ready <= (idx < BLK_QUADS) ? pick_ready(stall) : 1'b0;
      end
      if (idx < BLK_QUADS) begin
         $display("%s: block stream stopped before the last quadlet", name);
         timeouts++;
      end
      @(negedge clk);
      check_bit({name, " blk_valid after last"}, 1'b0, blk_valid);
   endtask

   // ------------------------------------------------------------------------
   // Tests
   // ------------------------------------------------------------------------

   task automatic reset_state();
      check_bit("reset sample_ready", 1'b1, sample_ready);
      check_bit("reset rd_start_ready", 1'b1, rd_start_ready);
      check_bit("reset blk_valid", 1'b0, blk_valid);
      read_block("reset block", 1'b0);       // Snapshot still cleared
   endtask

   task automatic layout_readback();
      randomize_chan_words();
      do_sample("layout");
      read_block("layout", 1'b0);
   endtask

   task automatic timestamp_gaps();
      do_sample("timestamp first");
      do_sample("timestamp back to back");   // Requested as soon as ready returns
      read_block("timestamp back to back", 1'b0);
      repeat (17) @(posedge clk);
      do_sample("timestamp gap");
      read_block("timestamp gap", 1'b0);
   endtask

   task automatic stalled_stream();
      read_block("backpressure", 1'b1);
      read_block("backpressure again", 1'b1);
   endtask

   task automatic sample_read_exclusion();
      int n;
      do_sample("exclusion first");
      randomize_chan_words();                // Newer words that miss this snapshot
      fork
         read_block("exclusion old block", 1'b1);
         begin
            n = 0;
            do begin
               @(negedge clk);
               n++;
            end while (!blk_valid && n < 200);
            if (!blk_valid) begin
               $display("exclusion: block stream never started");
               timeouts++;
            end
            do_sample("exclusion during stream");   // Held off until after last
         end
      join
      read_block("exclusion new block", 1'b0);
   endtask

   initial begin
      reset          <= 1'b1;
      sample_valid   <= 1'b0;
      reg_status     <= '0;
      reg_digio      <= '0;
      reg_temp       <= '0;
      fb_wr_valid    <= 1'b0;
      fb_wr_chan     <= '0;
      fb_wr_field    <= FB_ADC;
      fb_wr_data     <= '0;
      rd_start_valid <= 1'b0;
      blk_ready      <= 1'b0;
      for (int c = 0; c < NUM_CHAN; c++)
         for (int f = 0; f < NUM_FIELDS; f++)
            model_regs[c][f] = '0;
      for (int q = 0; q < BLK_QUADS; q++)
         snap_exp[q] = '0;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      zero_edge = cycle_cnt;                 // Counter held at 0 on this last reset edge
      @(negedge clk);
      reset_state();
      layout_readback();
      timestamp_gaps();
      stalled_stream();
      sample_read_exclusion();
      $display("Errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: rt_feedback.f
hw/rtfb_pkg.sv
hw/chan_fb_if.sv
hw/chan_regs.sv
hw/sample_data.sv
hw/block_reader.sv
hw/rt_feedback_top.sv
test/tb_rt_feedback.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := tb_rt_feedback
FILELIST := rt_feedback.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: simulate clean

# Build, run, then decide pass or fail from the log
simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
